//--- flist.f
src/ads1115_pkg.sv
src/frame_sequencer.sv
src/sda_transmitter.sv
src/sda_receiver.sv
src/ads1115_reader.sv
testbench/ads1115_slave_model.sv
testbench/tb_ads1115_reader.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_ads1115_reader

./obj_dir/Vtb_ads1115_reader > sim.log 2>&1 || true
cat sim.log

grep -q "TEST RESULT: PASS" sim.log

//--- testbench/tb_ads1115_reader.sv
`timescale 1ns/1ps

module tb_ads1115_reader;

    localparam int NUM_CASES      = 6;
    localparam int TIMEOUT_CYCLES = 78 + 1800 + 42 + NUM_CASES * (60 + 2000) + 200;

    typedef struct packed {
        logic [15:0] reading;
        logic [15:0] expected;
    } read_case_t;

    // One entry per read frame, in order
    localparam read_case_t CASES [NUM_CASES] = '{
        '{16'h0000, 16'h0000},
        '{16'hffff, 16'hffff},
        '{16'h8001, 16'h8001},
        '{16'h1234, 16'h1234},
        '{16'h5aa5, 16'h5aa5},
        '{16'h7ffe, 16'h7ffe}
    };

    logic        clk;
    logic        reset_n;
    logic        scl;
    logic        sda_out;
    logic        sda_oe;
    logic        sda_line;
    logic [15:0] lux_value;
    logic        lux_valid;
    logic [15:0] reading;
    logic [63:0] skip_mask;
    logic        frame_start;
    logic        frame_end;
    logic        slave_owns;
    logic [31:0] rx_bytes;
    int          rx_count;
    logic [1:0]  master_acks;
    logic        scl_q;
    logic        sda_q;
    int          cycle;
    int          frames;
    int          stop_cycle;
    int          errors_value;
    int          errors_bus;

    ads1115_reader u_dut (
        .i2c_sclk_local_200khz (clk),
        .reset_n               (reset_n),
        .sda_in                (sda_line),
        .scl                   (scl),
        .sda_out               (sda_out),
        .sda_oe                (sda_oe),
        .lux_value             (lux_value),
        .lux_valid             (lux_valid)
    );

    ads1115_slave_model u_slave (
        .clk         (clk),
        .scl         (scl),
        .sda_out     (sda_out),
        .sda_oe      (sda_oe),
        .reading     (reading),
        .skip_mask   (skip_mask),
        .sda         (sda_line),
        .frame_start (frame_start),
        .frame_end   (frame_end),
        .slave_owns  (slave_owns),
        .rx_bytes    (rx_bytes),
        .rx_count    (rx_count),
        .master_acks (master_acks)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Frame 0 config, frame 1 pointer, then reads
    task automatic compare_frame_bytes(input int idx);
        logic [31:0] exp_bytes;
        int          exp_count;
        if (idx == 0) begin
            exp_bytes = 32'h9001_c583;
            exp_count = 4;
        end else if (idx == 1) begin
            exp_bytes = 32'h0000_9000;
            exp_count = 2;
        end else begin
            exp_bytes = 32'h0000_0091;
            exp_count = 1;
        end
        assert (rx_bytes == exp_bytes && rx_count == exp_count) else begin
            errors_bus++;
            $display("Fail rx_bytes: frame %0d got %h (%0d bytes) expected %h (%0d bytes)",
                     idx, rx_bytes, rx_count, exp_bytes, exp_count);
        end
        if (idx >= 2) begin
            assert (master_acks == 2'b01) else begin
                errors_bus++;
                $display("Fail master_acks: frame %0d got %h expected 1", idx, master_acks);
            end
        end
    endtask

    // --------------------
    // Run limit
    // --------------------
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle == TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors: %0d value, %0d bus", errors_value, errors_bus);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // --------------------
    // Bus checks at the falling clock edge
    // --------------------
    always @(negedge clk) begin
        if (cycle >= 1 && cycle <= 5) begin
            assert (scl && !sda_oe && !lux_valid) else begin
                errors_bus++;
                $display("Fail reset outputs: scl=%h sda_oe=%h lux_valid=%h expected 1 0 0",
                         scl, sda_oe, lux_valid);
            end
        end
        if (slave_owns) begin
            assert (!sda_oe) else begin
                errors_bus++;
                $display("Fail sda_oe: got %h during a slave bit, expected 0", sda_oe);
            end
        end
        if (scl_q && scl && sda_line != sda_q) begin
            assert (frame_start || frame_end) else begin
                errors_bus++;
                $display("SDA changed while SCL was high inside a frame at cycle %0d", cycle);
            end
        end
        scl_q = scl;
        sda_q = sda_line;
        if (frame_start && frames == 1) begin
            assert (cycle - stop_cycle >= int'(ads1115_pkg::CONV_WAIT_CYCLES)) else begin
                errors_bus++;
                $display("Pointer frame began %0d cycles after the config STOP, too early",
                         cycle - stop_cycle);
            end
        end
        if (frame_end) begin
            compare_frame_bytes(frames);
            if (frames == 0) begin
                stop_cycle = cycle;
            end
            frames++;
        end
    end

    initial begin
        void'($urandom(32'h3fd4_d78c));
        skip_mask    = {$urandom, $urandom};
        cycle        = 0;
        frames       = 0;
        stop_cycle   = 0;
        errors_value = 0;
        errors_bus   = 0;
        scl_q        = 1'b1;
        sda_q        = 1'b1;
        reading      = CASES[0].reading;
        reset_n      = 1'b0;
        repeat (5) @(posedge clk);
        #1 reset_n = 1'b1;

        for (int i = 0; i < NUM_CASES; i++) begin
            @(negedge clk);
            while (!lux_valid) @(negedge clk);
            assert (lux_value == CASES[i].expected) else begin
                errors_value++;
                $display("Fail lux_value: case %0d got %h expected %h",
                         i, lux_value, CASES[i].expected);
            end
            if (i + 1 < NUM_CASES) begin
                reading = CASES[i + 1].reading;
            end
            @(negedge clk);
            assert (!lux_valid) else begin
                errors_value++;
                $display("Fail lux_valid: got %h one cycle after the pulse, expected 0",
                         lux_valid);
            end
        end

        // Let the last STOP complete
        repeat (3) @(negedge clk);
        assert (frames == NUM_CASES + 2) else begin
            errors_bus++;
            $display("Expected %0d frames on the bus but saw %0d", NUM_CASES + 2, frames);
        end

        $display("Errors: %0d value, %0d bus", errors_value, errors_bus);
        if (errors_value + errors_bus == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- testbench/ads1115_slave_model.sv
`timescale 1ns/1ps

module ads1115_slave_model (
    input  logic        clk,
    input  logic        scl,
    input  logic        sda_out,
    input  logic        sda_oe,
    input  logic [15:0] reading,
    input  logic [63:0] skip_mask,
    output logic        sda,
    output logic        frame_start,
    output logic        frame_end,
    output logic        slave_owns,
    output logic [31:0] rx_bytes,
    output int          rx_count,
    output logic [1:0]  master_acks
);

    logic        mline;
    logic        line;
    logic        scl_q;
    logic        line_q;
    logic        in_frame;
    logic        is_read;
    logic        pull;
    logic [7:0]  shift_in;
    logic [15:0] cur;
    int          pos;
    int          acks_given;

    initial begin
        sda         = 1'b1;
        scl_q       = 1'b1;
        line_q      = 1'b1;
        in_frame    = 1'b0;
        is_read     = 1'b0;
        pull        = 1'b0;
        slave_owns  = 1'b0;
        frame_start = 1'b0;
        frame_end   = 1'b0;
        rx_bytes    = '0;
        rx_count    = 0;
        master_acks = '0;
        pos         = 0;
        acks_given  = 0;
    end

    // Rising SCL: take a master bit, or the master ACK level in a read
    task automatic sample_bit();
        int b;
        int k;
        b = pos / 9;
        k = pos % 9;
        if (b == 0 || !is_read) begin
            if (k < 8) begin
                shift_in = {shift_in[6:0], line};
            end else begin
                rx_bytes = {rx_bytes[23:0], shift_in};
                rx_count++;
                if (b == 0) begin
                    is_read = shift_in[0];
                end
            end
        end else if (k == 8) begin
            master_acks = {master_acks[0], line};
        end
        pos++;
    endtask

    // Falling SCL: level for the coming bit
    task automatic choose_drive();
        int b;
        int k;
        b = pos / 9;
        k = pos % 9;
        slave_owns = 1'b0;
        pull       = 1'b0;
        if ((b == 0 || !is_read) && k == 8) begin
            // Some ACKs left to the pull-up
            slave_owns = 1'b1;
            pull       = !skip_mask[acks_given % 64];
            acks_given++;
        end else if (is_read && b >= 1 && b <= 2 && k < 8) begin
            slave_owns = 1'b1;
            pull       = !cur[15 - (b - 1) * 8 - k];
        end
    endtask

    // --------------------
    // Bus with pull-up, evaluated once DUT outputs settle
    // --------------------
    always begin
        @(posedge clk);
        #1;
        mline       = sda_oe ? sda_out : 1'b1;
        line        = mline & ~pull;
        frame_start = 1'b0;
        frame_end   = 1'b0;
        if (scl_q && scl && line_q && !line) begin
            in_frame    = 1'b1;
            is_read     = 1'b0;
            pos         = 0;
            rx_bytes    = '0;
            rx_count    = 0;
            master_acks = '0;
            cur         = reading;
            frame_start = 1'b1;
        end else if (scl_q && scl && !line_q && line) begin
            in_frame  = 1'b0;
            frame_end = 1'b1;
        end else if (in_frame && !scl_q && scl) begin
            sample_bit();
        end else if (in_frame && scl_q && !scl) begin
            choose_drive();
        end
        sda    = mline & ~pull;
        scl_q  = scl;
        line_q = sda;
    end

endmodule

//--- src/ads1115_reader.sv
`timescale 1ns/1ps

module ads1115_reader (
    input  logic        i2c_sclk_local_200khz,
    input  logic        reset_n,
    input  logic        sda_in,
    output logic        scl,
    output logic        sda_out,
    output logic        sda_oe,
    output logic [15:0] lux_value,
    output logic        lux_valid
);

    // Current frame, phase and slot shared by both SDA halves
    ads1115_pkg::bus_slot_t bus;

    frame_sequencer u_sequencer (
        .i2c_sclk_local_200khz (i2c_sclk_local_200khz),
        .reset_n               (reset_n),
        .bus                   (bus),
        .scl                   (scl)
    );

    // Master side of SDA
    sda_transmitter u_transmitter (
        .i2c_sclk_local_200khz (i2c_sclk_local_200khz),
        .reset_n               (reset_n),
        .bus                   (bus),
        .sda_out               (sda_out),
        .sda_oe                (sda_oe)
    );

    // Slave data capture
    sda_receiver u_receiver (
        .i2c_sclk_local_200khz (i2c_sclk_local_200khz),
        .reset_n               (reset_n),
        .bus                   (bus),
        .sda_in                (sda_in),
        .lux_value             (lux_value),
        .lux_valid             (lux_valid)
    );

endmodule

//--- src/sda_receiver.sv
`timescale 1ns/1ps

module sda_receiver (
    input  logic                   i2c_sclk_local_200khz,
    input  logic                   reset_n,
    input  ads1115_pkg::bus_slot_t bus,
    input  logic                   sda_in,
    output logic [15:0]            lux_value,
    output logic                   lux_valid
);

    logic [1:0]  byte_idx;
    logic [4:0]  bit_offs;
    logic        in_read;
    logic        sample_en;
    logic [15:0] shift_q;

    assign in_read  = bus.phase == ads1115_pkg::PH_DATA && bus.frame == ads1115_pkg::FR_READ;
    assign byte_idx = 2'(bus.slot / ads1115_pkg::SLOTS_PER_BYTE);
    assign bit_offs = 5'(bus.slot % ads1115_pkg::SLOTS_PER_BYTE);

    // SCL-high slots of the two data bytes, ACK slots skipped
    assign sample_en = in_read && byte_idx != 2'd0 && bit_offs < 5'd16 && bus.slot[0];

    // --------------------
    // Data capture
    // --------------------
    always_ff @(posedge i2c_sclk_local_200khz) begin
        if (sample_en) begin
            shift_q <= {shift_q[14:0], sda_in};
        end
    end

    // Publish once the NACK slot ends
    always_ff @(posedge i2c_sclk_local_200khz) begin
        if (!reset_n) begin
            lux_value <= '0;
            lux_valid <= 1'b0;
        end else begin
            lux_valid <= in_read && bus.last_slot;
            if (in_read && bus.last_slot) begin
                lux_value <= shift_q;
            end
        end
    end

    a_valid_single: assert property (@(posedge i2c_sclk_local_200khz) disable iff (!reset_n)
        lux_valid |=> !lux_valid);

endmodule

//--- src/sda_transmitter.sv
`timescale 1ns/1ps

module sda_transmitter (
    input  logic                   i2c_sclk_local_200khz,
    input  logic                   reset_n,
    input  ads1115_pkg::bus_slot_t bus,
    output logic                   sda_out,
    output logic                   sda_oe
);

    logic [1:0] byte_idx;
    logic [4:0] bit_offs;
    logic       ack_slot;
    logic [7:0] tx_byte;
    logic       sda_level;

    // Byte number and position within the byte
    assign byte_idx = 2'(bus.slot / ads1115_pkg::SLOTS_PER_BYTE);
    assign bit_offs = 5'(bus.slot % ads1115_pkg::SLOTS_PER_BYTE);
    assign ack_slot = bit_offs[4:1] == 4'd8;

    // Byte sent by the master in each frame
    always_comb begin
        case (bus.frame)
            ads1115_pkg::FR_CONFIG: begin
                case (byte_idx)
                    2'd0:    tx_byte = ads1115_pkg::ADDR_WR;
                    2'd1:    tx_byte = ads1115_pkg::PTR_CONFIG;
                    2'd2:    tx_byte = ads1115_pkg::ADC_CONFIG.bytes.msb;
                    default: tx_byte = ads1115_pkg::ADC_CONFIG.bytes.lsb;
                endcase
            end
            ads1115_pkg::FR_POINTER: begin
                tx_byte = (byte_idx == 2'd0) ? ads1115_pkg::ADDR_WR : ads1115_pkg::PTR_CONV;
            end
            default: tx_byte = ads1115_pkg::ADDR_RD;
        endcase
    end

    always_comb begin
        sda_oe  = 1'b0;
        sda_out = 1'b1;
        case (bus.phase)
            // High first, then low under high SCL
            ads1115_pkg::PH_START: begin
                sda_oe  = 1'b1;
                sda_out = bus.step == 2'd0;
            end
            ads1115_pkg::PH_STOP: begin
                sda_oe  = 1'b1;
                sda_out = bus.step == 2'(ads1115_pkg::EDGE_STEPS - 1);
            end
            ads1115_pkg::PH_DATA: begin
                if (bus.frame != ads1115_pkg::FR_READ || byte_idx == 2'd0) begin
                    // MSB first, inverted index gives 7 - bit
                    sda_oe  = !ack_slot;
                    sda_out = tx_byte[~bit_offs[3:1]];
                end else if (ack_slot) begin
                    // ACK after first data byte, NACK after the last
                    sda_oe  = 1'b1;
                    sda_out = byte_idx == 2'd2;
                end
            end
            default: ;
        endcase
    end

    // Line as seen on the wire with a pull-up
    assign sda_level = sda_oe ? sda_out : 1'b1;

    a_sda_stable_scl_high: assert property (
        @(posedge i2c_sclk_local_200khz) disable iff (!reset_n)
        (bus.phase == ads1115_pkg::PH_DATA && bus.slot[0]) |-> sda_level == $past(sda_level));

endmodule

//--- src/frame_sequencer.sv
`timescale 1ns/1ps

module frame_sequencer (
    input  logic                   i2c_sclk_local_200khz,
    input  logic                   reset_n,
    output ads1115_pkg::bus_slot_t bus,
    output logic                   scl
);

    localparam logic [1:0] STEP_LAST = 2'(ads1115_pkg::EDGE_STEPS - 1);

    ads1115_pkg::bus_slot_t bus_nxt;
    ads1115_pkg::slot_t     frame_len;
    logic [10:0]            wait_len;
    logic [10:0]            wait_cnt;
    logic [10:0]            wait_cnt_nxt;

    // Data slots per frame kind
    function automatic ads1115_pkg::slot_t len_of(input ads1115_pkg::frame_e fr);
        case (fr)
            ads1115_pkg::FR_CONFIG:  return ads1115_pkg::slot_t'(ads1115_pkg::CONFIG_SLOTS);
            ads1115_pkg::FR_POINTER: return ads1115_pkg::slot_t'(ads1115_pkg::POINTER_SLOTS);
            default:                 return ads1115_pkg::slot_t'(ads1115_pkg::READ_SLOTS);
        endcase
    endfunction

    // SCL level for a given bus position
    function automatic logic scl_of(input ads1115_pkg::bus_slot_t b);
        case (b.phase)
            ads1115_pkg::PH_START: return b.step != STEP_LAST;
            ads1115_pkg::PH_DATA:  return b.slot[0];
            ads1115_pkg::PH_STOP:  return b.step != 2'd0;
            ads1115_pkg::PH_WAIT:  return 1'b0;
            default:               return 1'b1;
        endcase
    endfunction

    assign frame_len = len_of(bus.frame);

    // Conversion wait after config, read gap after every read
    assign wait_len = (bus.frame == ads1115_pkg::FR_CONFIG) ?
                      11'(ads1115_pkg::CONV_WAIT_CYCLES) :
                      11'(ads1115_pkg::READ_GAP_CYCLES);

    // --------------------
    // Next state
    // --------------------
    always_comb begin
        bus_nxt           = bus;
        bus_nxt.last_slot = 1'b0;
        wait_cnt_nxt      = '0;
        case (bus.phase)
            ads1115_pkg::PH_IDLE: begin
                bus_nxt.frame = ads1115_pkg::FR_CONFIG;
                bus_nxt.phase = ads1115_pkg::PH_START;
                bus_nxt.step  = '0;
                bus_nxt.slot  = '0;
            end
            ads1115_pkg::PH_START: begin
                if (bus.step == STEP_LAST) begin
                    bus_nxt.phase = ads1115_pkg::PH_DATA;
                    bus_nxt.slot  = '0;
                end else begin
                    bus_nxt.step = bus.step + 2'd1;
                end
            end
            ads1115_pkg::PH_DATA: begin
                if (bus.last_slot) begin
                    bus_nxt.phase = ads1115_pkg::PH_STOP;
                    bus_nxt.step  = '0;
                end else begin
                    bus_nxt.slot      = bus.slot + 7'd1;
                    bus_nxt.last_slot = (bus.slot + 7'd2) == frame_len;
                end
            end
            ads1115_pkg::PH_STOP: begin
                if (bus.step != STEP_LAST) begin
                    bus_nxt.step = bus.step + 2'd1;
                end else if (bus.frame == ads1115_pkg::FR_POINTER) begin
                    // Pointer write runs straight into the first read
                    bus_nxt.frame = ads1115_pkg::FR_READ;
                    bus_nxt.phase = ads1115_pkg::PH_START;
                    bus_nxt.step  = '0;
                    bus_nxt.slot  = '0;
                end else begin
                    bus_nxt.phase = ads1115_pkg::PH_WAIT;
                end
            end
            ads1115_pkg::PH_WAIT: begin
                if (wait_cnt == wait_len - 11'd1) begin
                    bus_nxt.frame = (bus.frame == ads1115_pkg::FR_CONFIG) ?
                                    ads1115_pkg::FR_POINTER : ads1115_pkg::FR_READ;
                    bus_nxt.phase = ads1115_pkg::PH_START;
                    bus_nxt.step  = '0;
                    bus_nxt.slot  = '0;
                end else begin
                    wait_cnt_nxt = wait_cnt + 11'd1;
                end
            end
            default: bus_nxt.phase = ads1115_pkg::PH_IDLE;
        endcase
    end

    // SCL is registered from the next position so it lines up with bus
    always_ff @(posedge i2c_sclk_local_200khz) begin
        if (!reset_n) begin
            bus <= '{frame: ads1115_pkg::FR_CONFIG, phase: ads1115_pkg::PH_IDLE,
                     step: 2'd0, slot: 7'd0, last_slot: 1'b0};
            wait_cnt <= '0;
            scl      <= 1'b1;
        end else begin
            bus      <= bus_nxt;
            wait_cnt <= wait_cnt_nxt;
            scl      <= scl_of(bus_nxt);
        end
    end

    // --------------------
    // Checks
    // --------------------
    a_slot_in_frame: assert property (@(posedge i2c_sclk_local_200khz) disable iff (!reset_n)
        bus.phase == ads1115_pkg::PH_DATA |-> bus.slot < frame_len);

    // Flag marks exactly the final data slot of the frame
    a_last_in_data: assert property (@(posedge i2c_sclk_local_200khz) disable iff (!reset_n)
        bus.last_slot == (bus.phase == ads1115_pkg::PH_DATA && bus.slot == frame_len - 7'd1));

endmodule

//--- src/ads1115_pkg.sv
package ads1115_pkg;

    // --------------------
    // Bus addressing
    // --------------------
    localparam logic [6:0] DEV_ADDR   = 7'h48;
    localparam logic [7:0] ADDR_WR    = {DEV_ADDR, 1'b0};
    localparam logic [7:0] ADDR_RD    = {DEV_ADDR, 1'b1};
    localparam logic [7:0] PTR_CONV   = 8'h00;
    localparam logic [7:0] PTR_CONFIG = 8'h01;

    // Eight bits plus ACK, two slots each
    localparam int unsigned SLOTS_PER_BYTE = 18;
    localparam int unsigned CONFIG_SLOTS   = 4 * SLOTS_PER_BYTE;
    localparam int unsigned POINTER_SLOTS  = 2 * SLOTS_PER_BYTE;
    localparam int unsigned READ_SLOTS     = 3 * SLOTS_PER_BYTE;
    localparam int unsigned EDGE_STEPS     = 3;

    // Waits in cycles of the 200 kHz tick
    localparam int unsigned CONV_WAIT_CYCLES = 1800;
    localparam int unsigned READ_GAP_CYCLES  = 2000;

    // --------------------
    // Sequencer types
    // --------------------
    typedef enum logic [1:0] {
        FR_CONFIG,
        FR_POINTER,
        FR_READ
    } frame_e;

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_START,
        PH_DATA,
        PH_STOP,
        PH_WAIT
    } phase_e;

    typedef logic [6:0] slot_t;

    typedef struct packed {
        frame_e     frame;
        phase_e     phase;
        logic [1:0] step;
        slot_t      slot;
        logic       last_slot;
    } bus_slot_t;

    // --------------------
    // ADS1115 config word
    // --------------------
    typedef struct packed {
        logic       os;
        logic [2:0] mux;
        logic [2:0] pga;
        logic       mode;
        logic [2:0] dr;
        logic       comp_mode;
        logic       comp_pol;
        logic       comp_lat;
        logic [1:0] comp_que;
    } config_fields_t;

    typedef struct packed {
        logic [7:0] msb;
        logic [7:0] lsb;
    } config_bytes_t;

    typedef union packed {
        config_fields_t fields;
        config_bytes_t  bytes;
    } config_reg_u;

    // AIN0 vs GND, 2.048 V range, single shot, 128 SPS, comparator off
    localparam config_fields_t ADC_CONFIG_FIELDS = '{
        os: 1'b1, mux: 3'b100, pga: 3'b010, mode: 1'b1, dr: 3'b100,
        comp_mode: 1'b0, comp_pol: 1'b0, comp_lat: 1'b0, comp_que: 2'b11
    };
    localparam config_reg_u ADC_CONFIG = config_reg_u'(ADC_CONFIG_FIELDS);

endpackage
